/* filelist.f */
src/dma_bus_pkg.sv
src/cpu_sm_terms.sv
src/cpu_sm_outputs.sv
src/cpu_sm.sv
src/dma_fifo.sv
src/resdmac_top.sv
verification/resdmac_assertions.sv
verification/tb_resdmac.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_resdmac -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_resdmac > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

if grep -qx "Simulation passed" "$log"; then
    exit 0
fi
echo "Pass line not found in $log"
exit 1

/* src/cpu_sm.sv */
// CPU-side bus master, registering state, strobes, address and remaining longwords
`timescale 1ns/1ps
`default_nettype none

module cpu_sm #(
    parameter int count_width = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic                     to_memory,
    input  logic [count_width-1:0]   xfer_longs,
    input  logic [31:0]              start_addr,
    input  logic                     bgrant_,
    input  logic                     dsack,
    input  logic                     sterm_,
    output dma_bus_pkg::sm_strobes_t strobes,
    output logic [31:0]              bus_addr
);

    dma_bus_pkg::sm_state_e   state;
    dma_bus_pkg::sm_state_e   next_state;
    dma_bus_pkg::sm_terms_t   terms;
    dma_bus_pkg::sm_strobes_t strobes_d;
    logic                     to_mem_q;
    logic [count_width-1:0]   remaining;
    logic [31:0]              long_addr;
    logic                     last_long;
    logic                     lo_half;

    // Checked in next_long, before incno takes effect
    assign last_long = (remaining == count_width'(1));

    cpu_sm_terms u_terms (
        .state     (state),
        .to_memory (to_mem_q),
        .start     (start),
        .bgrant_   (bgrant_),
        .last_long (last_long),
        .terms     (terms)
    );

    cpu_sm_outputs u_outputs (
        .terms      (terms),
        .dsack      (dsack),
        .sterm_     (sterm_),
        .next_state (next_state),
        .strobes_d  (strobes_d)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= dma_bus_pkg::idle;
            strobes   <= '0;
            to_mem_q  <= 1'b0;
            remaining <= '0;
        end else begin
            state   <= next_state;
            strobes <= strobes_d;
            if (terms.idle_start) begin
                to_mem_q  <= to_memory;
                remaining <= xfer_longs;
            end else if (strobes.incno) begin
                remaining <= remaining - count_width'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (terms.idle_start) begin
            long_addr <= start_addr;
        end else if (strobes.incno) begin
            long_addr <= long_addr + 32'd4;
        end
    end

    // Second word of a 16-bit longword sits two bytes up
    assign lo_half  = (state == dma_bus_pkg::addr_lo) | (state == dma_bus_pkg::wait_lo);
    assign bus_addr = long_addr + {30'd0, lo_half, 1'b0};

endmodule

`default_nettype wire

/* src/cpu_sm_outputs.sv */
// Next-state and next-cycle strobe equations of the bus master, built from the product terms
`timescale 1ns/1ps
`default_nettype none

module cpu_sm_outputs (
    input  dma_bus_pkg::sm_terms_t   terms,
    input  logic                     dsack,
    input  logic                     sterm_,
    output dma_bus_pkg::sm_state_e   next_state,
    output dma_bus_pkg::sm_strobes_t strobes_d
);

    // Acknowledge groups
    logic ack;
    logic ack32;
    logic ack16;

    // Shared sub-products
    logic hi_addr;
    logic hi_wait;
    logic lo_addr;
    logic lo_wait;
    logic hi_stall;
    logic lo_stall;
    logic hi_half;
    logic cycle_group;
    logic long_to_mem;
    logic long_from_mem;
    logic long_done;
    logic owned;

    // sterm_ wins when both acknowledges show up together
    assign ack32 = ~sterm_;
    assign ack16 = sterm_ & dsack;
    assign ack   = ack32 | dsack;

    assign hi_addr = terms.hi_to_mem | terms.hi_from_mem;
    assign hi_wait = terms.wait_hi_to_mem | terms.wait_hi_from_mem;
    assign lo_addr = terms.lo_to_mem | terms.lo_from_mem;
    assign lo_wait = terms.wait_lo_to_mem | terms.wait_lo_from_mem;

    assign hi_stall = hi_wait & ~ack;
    assign lo_stall = lo_wait & ~ack;
    assign hi_half  = hi_wait & ack16;

    // Strobes stay up through the address cycle and every wait state
    assign cycle_group = hi_addr | hi_stall | lo_addr | lo_stall;

    // Longword complete on a 32-bit ack or on the second half of a 16-bit one
    assign long_to_mem   = (terms.wait_hi_to_mem & ack32) | (terms.wait_lo_to_mem & ack);
    assign long_from_mem = (terms.wait_hi_from_mem & ack32) | (terms.wait_lo_from_mem & ack);
    assign long_done     = long_to_mem | long_from_mem;

    assign owned = terms.granted | terms.own | hi_addr | hi_wait | lo_addr | lo_wait |
                   terms.next_more;

    always_comb begin
        if (terms.idle_start | terms.req_wait) begin
            next_state = dma_bus_pkg::req_bus;
        end else if (terms.granted) begin
            next_state = dma_bus_pkg::own_bus;
        end else if (terms.own | terms.next_more) begin
            next_state = dma_bus_pkg::addr_hi;
        end else if (hi_addr | hi_stall) begin
            next_state = dma_bus_pkg::wait_hi;
        end else if (hi_half) begin
            next_state = dma_bus_pkg::addr_lo;
        end else if (lo_addr | lo_stall) begin
            next_state = dma_bus_pkg::wait_lo;
        end else if (long_done) begin
            next_state = dma_bus_pkg::next_long;
        end else if (terms.last_long) begin
            next_state = dma_bus_pkg::release_bus;
        end else begin
            next_state = dma_bus_pkg::idle;
        end
    end

    always_comb begin
        strobes_d.breq  = terms.idle_start | terms.req_wait;
        strobes_d.bgack = owned;
        strobes_d.pas   = cycle_group;
        strobes_d.pds   = cycle_group;
        // Second word requests two bytes
        strobes_d.size1 = lo_addr | lo_stall;
        strobes_d.rw    = terms.hi_from_mem | terms.wait_hi_from_mem |
                          terms.lo_from_mem | terms.wait_lo_from_mem;

        // Write lanes with the high word first
        strobes_d.f2cpuh    = terms.hi_to_mem | (terms.wait_hi_to_mem & ~ack);
        strobes_d.f2cpul    = terms.hi_to_mem | (terms.wait_hi_to_mem & ~ack);
        strobes_d.bridgeout = terms.lo_to_mem | (terms.wait_lo_to_mem & ~ack);

        // Read lanes into the FIFO tail
        strobes_d.plhw     = terms.wait_hi_from_mem & ack;
        strobes_d.pllw     = long_from_mem;
        strobes_d.bridgein = terms.wait_lo_from_mem & ack;

        strobes_d.incfifo = long_from_mem;
        strobes_d.decfifo = long_to_mem;
        strobes_d.incno   = long_done;
        strobes_d.done    = terms.rel;
    end

endmodule

`default_nettype wire

/* src/cpu_sm_terms.sv */
// Product term decoder for the CPU-side state machine, feeding the output equations
`timescale 1ns/1ps
`default_nettype none

module cpu_sm_terms (
    input  dma_bus_pkg::sm_state_e state,
    input  logic                   to_memory,
    input  logic                   start,
    input  logic                   bgrant_,
    input  logic                   last_long,
    output dma_bus_pkg::sm_terms_t terms
);

    logic in_idle;
    logic in_req;
    logic in_own;
    logic in_addr_hi;
    logic in_wait_hi;
    logic in_addr_lo;
    logic in_wait_lo;
    logic in_next;
    logic in_release;

    // One decode per state
    assign in_idle    = (state == dma_bus_pkg::idle);
    assign in_req     = (state == dma_bus_pkg::req_bus);
    assign in_own     = (state == dma_bus_pkg::own_bus);
    assign in_addr_hi = (state == dma_bus_pkg::addr_hi);
    assign in_wait_hi = (state == dma_bus_pkg::wait_hi);
    assign in_addr_lo = (state == dma_bus_pkg::addr_lo);
    assign in_wait_lo = (state == dma_bus_pkg::wait_lo);
    assign in_next    = (state == dma_bus_pkg::next_long);
    assign in_release = (state == dma_bus_pkg::release_bus);

    always_comb begin
        // Arbitration
        terms.idle_start = in_idle & start;
        terms.req_wait   = in_req & bgrant_;
        terms.granted    = in_req & ~bgrant_;
        terms.own        = in_own;

        // First or only word of a longword
        terms.hi_to_mem        = in_addr_hi & to_memory;
        terms.hi_from_mem      = in_addr_hi & ~to_memory;
        terms.wait_hi_to_mem   = in_wait_hi & to_memory;
        terms.wait_hi_from_mem = in_wait_hi & ~to_memory;

        // Second word on a 16-bit port
        terms.lo_to_mem        = in_addr_lo & to_memory;
        terms.lo_from_mem      = in_addr_lo & ~to_memory;
        terms.wait_lo_to_mem   = in_wait_lo & to_memory;
        terms.wait_lo_from_mem = in_wait_lo & ~to_memory;

        // Progress through the block
        terms.next_more = in_next & ~last_long;
        terms.last_long = in_next & last_long;
        terms.rel       = in_release;
    end

endmodule

`default_nettype wire

/* src/dma_bus_pkg.sv */
// Shared types and bus constants for the DMA engine, referenced by scoped name from the RTL
`default_nettype none

package dma_bus_pkg;

    // Bus and FIFO geometry
    localparam int data_width    = 32;
    localparam int half_width    = 16;
    localparam int fifo_depth_lg = 3;

    // CPU-side bus master states
    typedef enum logic [3:0] {
        idle        = 4'd0,
        req_bus     = 4'd1,
        own_bus     = 4'd2,
        addr_hi     = 4'd3,
        wait_hi     = 4'd4,
        addr_lo     = 4'd5,
        wait_lo     = 4'd6,
        next_long   = 4'd7,
        release_bus = 4'd8
    } sm_state_e;

    // One state qualified by direction or progress
    typedef struct packed {
        logic idle_start;
        logic req_wait;
        logic granted;
        logic own;
        logic hi_to_mem;
        logic hi_from_mem;
        logic wait_hi_to_mem;
        logic wait_hi_from_mem;
        logic lo_to_mem;
        logic lo_from_mem;
        logic wait_lo_to_mem;
        logic wait_lo_from_mem;
        logic next_more;
        logic last_long;
        logic rel;
    } sm_terms_t;

    // Registered bus pins and data path controls
    typedef struct packed {
        logic breq;
        logic bgack;
        logic pas;
        logic pds;
        logic size1;
        logic rw;
        logic f2cpuh;
        logic f2cpul;
        logic bridgeout;
        logic plhw;
        logic pllw;
        logic bridgein;
        logic incfifo;
        logic decfifo;
        logic incno;
        logic done;
    } sm_strobes_t;

endpackage

`default_nettype wire

/* src/dma_fifo.sv */
// Longword FIFO between the host port and the bus, with word-lane loads and steered bus lanes
`timescale 1ns/1ps
`default_nettype none

module dma_fifo #(
    parameter int fifo_depth_lg = 3
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wr_en,
    input  logic [dma_bus_pkg::data_width-1:0]  wr_data,
    input  logic                                rd_en,
    output logic [dma_bus_pkg::data_width-1:0]  rd_data,
    output logic [fifo_depth_lg:0]              count,
    input  dma_bus_pkg::sm_strobes_t            strobes,
    input  logic [dma_bus_pkg::data_width-1:0]  bus_data_in,
    output logic [dma_bus_pkg::data_width-1:0]  bus_data_out
);

    localparam int depth = 1 << fifo_depth_lg;
    localparam int dw    = dma_bus_pkg::data_width;
    localparam int hw    = dma_bus_pkg::half_width;

    logic [dw-1:0]            mem [depth];
    logic [fifo_depth_lg-1:0] wr_ptr;
    logic [fifo_depth_lg-1:0] rd_ptr;
    logic [dw-1:0]            din_q;
    logic [dw-1:0]            head;
    logic [hw-1:0]            lo_src;
    logic                     push;
    logic                     pop;

    // Host and bus share the pointers, direction decides which side moves each
    assign push = wr_en | strobes.incfifo;
    assign pop  = rd_en | strobes.decfifo;

    // Bus data is taken on the acknowledge edge, loads follow a cycle later
    always_ff @(posedge clk) begin
        din_q <= bus_data_in;
    end

    // 16-bit ports deliver the low word on the upper lanes
    assign lo_src = strobes.bridgein ? din_q[dw-1:hw] : din_q[hw-1:0];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end else begin
            if (strobes.plhw) begin
                mem[wr_ptr][dw-1:hw] <= din_q[dw-1:hw];
            end
            if (strobes.pllw) begin
                mem[wr_ptr][hw-1:0] <= lo_src;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head    = mem[rd_ptr];
    assign rd_data = head;

    // Lane steering toward the bus
    always_comb begin
        bus_data_out = '0;
        if (strobes.f2cpuh) begin
            bus_data_out[dw-1:hw] = head[dw-1:hw];
        end else if (strobes.bridgeout) begin
            bus_data_out[dw-1:hw] = head[hw-1:0];
        end
        if (strobes.f2cpul) begin
            bus_data_out[hw-1:0] = head[hw-1:0];
        end
    end

endmodule

`default_nettype wire

/* src/resdmac_top.sv */
// DMA engine top level joining the bus master, the FIFO and the bus pins
`timescale 1ns/1ps
`default_nettype none

module resdmac_top #(
    parameter int fifo_depth_lg = dma_bus_pkg::fifo_depth_lg,
    parameter int count_width   = fifo_depth_lg + 1
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               start,
    input  logic                               to_memory,
    input  logic [count_width-1:0]             xfer_longs,
    input  logic [31:0]                        start_addr,
    input  logic                               fifo_wr_en,
    input  logic [dma_bus_pkg::data_width-1:0] fifo_wr_data,
    input  logic                               fifo_rd_en,
    output logic [dma_bus_pkg::data_width-1:0] fifo_rd_data,
    output logic [fifo_depth_lg:0]             fifo_count,
    output logic                               done,
    output logic                               breq,
    output logic                               bgack,
    output logic                               pas,
    output logic                               pds,
    output logic                               rw,
    output logic                               size1,
    output logic [31:0]                        bus_addr,
    output logic [dma_bus_pkg::data_width-1:0] bus_data_out,
    input  logic                               bgrant_,
    input  logic [dma_bus_pkg::data_width-1:0] bus_data_in,
    input  logic                               dsack,
    input  logic                               sterm_
);

    dma_bus_pkg::sm_strobes_t strobes;

    cpu_sm #(
        .count_width (count_width)
    ) u_cpu_sm (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .to_memory  (to_memory),
        .xfer_longs (xfer_longs),
        .start_addr (start_addr),
        .bgrant_    (bgrant_),
        .dsack      (dsack),
        .sterm_     (sterm_),
        .strobes    (strobes),
        .bus_addr   (bus_addr)
    );

    dma_fifo #(
        .fifo_depth_lg (fifo_depth_lg)
    ) u_fifo (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (fifo_wr_en),
        .wr_data      (fifo_wr_data),
        .rd_en        (fifo_rd_en),
        .rd_data      (fifo_rd_data),
        .count        (fifo_count),
        .strobes      (strobes),
        .bus_data_in  (bus_data_in),
        .bus_data_out (bus_data_out)
    );

    // Bus pins straight from the strobe register
    assign breq  = strobes.breq;
    assign bgack = strobes.bgack;
    assign pas   = strobes.pas;
    assign pds   = strobes.pds;
    assign rw    = strobes.rw;
    assign size1 = strobes.size1;
    assign done  = strobes.done;

endmodule

`default_nettype wire

/* verification/resdmac_assertions.sv */
// Concurrent bus protocol checks, bound into the DMA top level for every simulation
`timescale 1ns/1ps
`default_nettype none

module resdmac_assertions (
    input logic clk,
    input logic reset,
    input logic breq,
    input logic bgack,
    input logic bgrant_,
    input logic pas,
    input logic dsack,
    input logic sterm_
);

    // Ownership only after the arbiter has granted
    bgack_after_grant: assert property (@(posedge clk) disable iff (reset)
        $rose(bgack) |-> $past(!bgrant_))
        else $error("bgack rose without bgrant_ low on the clock before");

    pas_while_owner: assert property (@(posedge clk) disable iff (reset)
        pas |-> bgack)
        else $error("pas asserted while bgack is low");

    req_or_own: assert property (@(posedge clk) disable iff (reset)
        !(breq && bgack))
        else $error("breq and bgack high together");

    // Wait states hold the strobe
    pas_until_ack: assert property (@(posedge clk) disable iff (reset)
        (pas && sterm_ && !dsack) |=> pas)
        else $error("pas fell without an acknowledge");

endmodule

bind resdmac_top resdmac_assertions u_bus_checks (
    .clk     (clk),
    .reset   (reset),
    .breq    (breq),
    .bgack   (bgack),
    .bgrant_ (bgrant_),
    .pas     (pas),
    .dsack   (dsack),
    .sterm_  (sterm_)
);

`default_nettype wire

/* verification/tb_resdmac.sv */
// Self-checking testbench for the DMA engine with arbiter and memory models, run from a row table
`timescale 1ns/1ps
`default_nettype none

module tb_resdmac;

    typedef struct packed {
        logic        to_mem;
        logic        port16;
        logic [31:0] start_addr;
        logic [3:0]  longs;
        logic [1:0]  waits;
    } row_t;

    localparam int num_rows = 8;
    // to_mem, port16, start address, longwords, wait states
    localparam row_t rows [num_rows] = '{
        '{1'b1, 1'b0, 32'h0010_0200, 4'd4, 2'd0},
        '{1'b1, 1'b1, 32'h0010_0240, 4'd3, 2'd1},
        '{1'b0, 1'b0, 32'h0010_0280, 4'd5, 2'd0},
        '{1'b0, 1'b1, 32'h0010_02c0, 4'd4, 2'd2},
        '{1'b1, 1'b0, 32'h0010_0300, 4'd8, 2'd3},
        '{1'b0, 1'b0, 32'h0010_0340, 4'd2, 2'd3},
        '{1'b1, 1'b1, 32'h0010_0380, 4'd1, 2'd0},
        '{1'b0, 1'b1, 32'h0010_03a0, 4'd8, 2'd3}
    };

    logic        clk = 1'b0;
    logic        reset;
    logic        start;
    logic        to_memory;
    logic [3:0]  xfer_longs;
    logic [31:0] start_addr;
    logic        fifo_wr_en;
    logic [31:0] fifo_wr_data;
    logic        fifo_rd_en;
    logic [31:0] fifo_rd_data;
    logic [3:0]  fifo_count;
    logic        done;
    logic        breq;
    logic        bgack;
    logic        pas;
    logic        pds;
    logic        rw;
    logic        size1;
    logic [31:0] bus_addr;
    logic [31:0] bus_data_out;
    logic        bgrant_ = 1'b1;
    logic [31:0] bus_data_in = '0;
    logic        dsack = 1'b0;
    logic        sterm_ = 1'b1;

    logic [31:0] mem_model [256];
    logic [31:0] exp_data [8];
    row_t        cur = '0;
    logic [31:0] lfsr_state = 32'h17b3;
    int          grant_delay = 0;
    int          grant_cnt = 0;
    logic        grant_given = 1'b0;
    logic        ack_on = 1'b0;
    int          wait_cnt = 0;
    int          bus_cycles = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          fail_count = 0;

    resdmac_top #(
        .fifo_depth_lg (3),
        .count_width   (4)
    ) i_dut (
        .clk (clk), .reset (reset), .start (start), .to_memory (to_memory),
        .xfer_longs (xfer_longs), .start_addr (start_addr), .fifo_wr_en (fifo_wr_en),
        .fifo_wr_data (fifo_wr_data), .fifo_rd_en (fifo_rd_en), .fifo_rd_data (fifo_rd_data),
        .fifo_count (fifo_count), .done (done), .breq (breq), .bgack (bgack), .pas (pas),
        .pds (pds), .rw (rw), .size1 (size1), .bus_addr (bus_addr),
        .bus_data_out (bus_data_out), .bgrant_ (bgrant_), .bus_data_in (bus_data_in),
        .dsack (dsack), .sterm_ (sterm_)
    );

    always #50 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // Worst case per longword is two bus cycles plus next_long
    function automatic int run_limit();
        int total;
        total = 200;
        for (int r = 0; r < num_rows; r++) begin
            total += 40 + int'(rows[r].longs) * (2 * (int'(rows[r].waits) + 3) + 2);
        end
        return total;
    endfunction

    task automatic abort_run(input string reason);
        fail_count++;
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic verify(input logic ok, input string what);
        assert (ok) else abort_run($sformatf("CHECK FAILED at %0t ns: %s", $time, what));
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            abort_run($sformatf("Timeout, no result after %0d clock cycles", cycle_count));
        end
    end

    // Arbiter grants after a per-row delay and withdraws once bgack is up
    always @(negedge clk) begin
        if (reset || bgack) begin
            bgrant_ = 1'b1;
            grant_cnt = 0;
        end else if (breq) begin
            if (grant_cnt >= grant_delay) begin
                bgrant_ = 1'b0;
                grant_given = 1'b1;
            end else begin
                grant_cnt++;
            end
        end
    end

    task automatic answer_cycle();
        logic [7:0]  idx;
        logic [31:0] want_addr;
        logic [15:0] half;
        idx = bus_addr[9:2];
        if (cur.port16) begin
            want_addr = cur.start_addr + 32'(bus_cycles / 2) * 32'd4 + 32'(bus_cycles % 2) * 32'd2;
        end else begin
            want_addr = cur.start_addr + 32'(bus_cycles) * 32'd4;
        end
        verify(bus_addr == want_addr, $sformatf("bus_addr %h, expected %h", bus_addr, want_addr));
        if (!cur.port16) begin
            verify(!size1, "size1 high on a 32-bit port");
        end else if (bus_addr[1]) begin
            verify(size1, "size1 low on the second word of a 16-bit port");
        end
        if (cur.to_mem) begin
            if (!cur.port16) begin
                mem_model[idx] = bus_data_out;
            end else if (!bus_addr[1]) begin
                mem_model[idx][31:16] = bus_data_out[31:16];
            end else begin
                mem_model[idx][15:0] = bus_data_out[31:16];
            end
        end else if (!cur.port16) begin
            bus_data_in = mem_model[idx];
        end else begin
            half = bus_addr[1] ? mem_model[idx][15:0] : mem_model[idx][31:16];
            // Lower lanes carry junk on a 16-bit port
            bus_data_in = {half, ~half};
        end
        sterm_ = cur.port16;
        dsack = cur.port16;
        bus_cycles++;
        wait_cnt = 0;
        ack_on = 1'b1;
    endtask

    // Memory answers pas after the row's wait states and holds the ack until pas falls
    always @(negedge clk) begin
        if (reset) begin
            ack_on = 1'b0;
            wait_cnt = 0;
            sterm_ = 1'b1;
            dsack = 1'b0;
        end else if (ack_on) begin
            verify(!pas && !pds, "pas or pds still high after the acknowledge");
            ack_on = 1'b0;
            sterm_ = 1'b1;
            dsack = 1'b0;
        end else if (pas) begin
            verify(pds, "pds low while pas is high");
            verify(rw == !cur.to_mem, "rw does not match the transfer direction");
            if (wait_cnt < int'(cur.waits)) begin
                wait_cnt++;
            end else begin
                answer_cycle();
            end
        end else begin
            verify(!pds, "pds high while pas is low");
            verify(wait_cnt == 0, "pas fell before the acknowledge");
        end
    end

    task automatic fill_fifo(input int n);
        for (int i = 0; i < n; i++) begin
            fifo_wr_en = 1'b1;
            fifo_wr_data = exp_data[i];
            @(negedge clk);
        end
        fifo_wr_en = 1'b0;
    endtask

    task automatic drain_fifo(input int n);
        for (int i = 0; i < n; i++) begin
            verify(fifo_rd_data == exp_data[i],
                   $sformatf("FIFO longword %0d is %h, expected %h", i, fifo_rd_data, exp_data[i]));
            fifo_rd_en = 1'b1;
            @(negedge clk);
        end
        fifo_rd_en = 1'b0;
        verify(fifo_count == 4'd0, "FIFO not empty after draining");
    endtask

    task automatic run_row(input row_t r);
        logic [31:0] word;
        logic        bgack_seen;
        logic        bgack_d1;
        logic        bgack_d2;
        int          base;
        cur = r;
        base = int'(r.start_addr[9:2]);
        bgack_seen = 1'b0;
        bgack_d1 = 1'b0;
        bgack_d2 = 1'b0;
        for (int i = 0; i < int'(r.longs); i++) begin
            take_bits(32, word);
            exp_data[i] = word;
        end
        take_bits(2, word);
        grant_delay = int'(word[1:0]);
        if (r.to_mem) begin
            fill_fifo(int'(r.longs));
            verify(fifo_count == r.longs, "fifo_count wrong after filling");
        end else begin
            for (int i = 0; i < int'(r.longs); i++) begin
                mem_model[base + i] = exp_data[i];
            end
        end
        bus_cycles = 0;
        grant_given = 1'b0;
        to_memory = r.to_mem;
        xfer_longs = r.longs;
        start_addr = r.start_addr;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        verify(breq, "breq did not rise one cycle after start");
        while (!done) begin
            start = 1'b0;
            to_memory = r.to_mem;
            if (bgack && !bgack_seen) begin
                verify(grant_given, "bgack rose before bgrant_ went low");
                bgack_seen = 1'b1;
                // Second start while busy
                start = 1'b1;
                to_memory = !r.to_mem;
                xfer_longs = 4'd1;
            end
            bgack_d2 = bgack_d1;
            bgack_d1 = bgack;
            @(negedge clk);
        end
        start = 1'b0;
        verify(!bgack && !bgack_d1 && bgack_d2, "done not one cycle after bgack fell");
        verify(bus_cycles == (r.port16 ? 2 : 1) * int'(r.longs),
               $sformatf("%0d bus cycles for %0d longwords", bus_cycles, r.longs));
        repeat (4) begin
            @(negedge clk);
            verify(!done && !breq, "done repeated or an ignored start began a transfer");
        end
        if (r.to_mem) begin
            verify(fifo_count == 4'd0, "fifo_count did not drop by the transfer length");
            for (int i = 0; i < int'(r.longs); i++) begin
                verify(mem_model[base + i] == exp_data[i],
                       $sformatf("memory longword %0d is %h, expected %h",
                                 i, mem_model[base + i], exp_data[i]));
            end
        end else begin
            verify(fifo_count == r.longs, "fifo_count wrong after reading memory");
            drain_fifo(int'(r.longs));
        end
    endtask

    initial begin
        reset = 1'b1;
        start = 1'b0;
        to_memory = 1'b0;
        xfer_longs = '0;
        start_addr = '0;
        fifo_wr_en = 1'b0;
        fifo_wr_data = '0;
        fifo_rd_en = 1'b0;
        cycle_limit = run_limit();
        for (int i = 0; i < 256; i++) begin
            mem_model[i] = (32'(i) + 32'd1) * 32'h9e37_79b1;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        verify(!breq && !bgack && !pas && !done && fifo_count == 4'd0,
               "outputs not idle after reset");
        for (int r = 0; r < num_rows; r++) begin
            run_row(rows[r]);
        end
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
